// ==== fifoPkg.sv ====
// --------------------
// shared geometry and types for the dual-clock FIFO
// import into module bodies, scoped names in port lists
// --------------------
package fifoPkg;

    // --------------------
    // geometry
    // --------------------
    localparam int bufDepth   = 256;                // memory words
    localparam int dataWidth  = 24;                 // bits per data word
    localparam int addrWidth  = $clog2(bufDepth);   // 8 for 256 words
    localparam int ptrWidth   = addrWidth + 1;      // extra wrap bit
    localparam int fullMargin = 6;                  // free slots left when full rises

    // --------------------
    // types
    // --------------------
    typedef logic [dataWidth-1:0] fifoData_t;       // one payload word
    typedef logic [addrWidth-1:0] fifoAddr_t;       // memory index
    typedef logic [ptrWidth-1:0]  fifoPtr_t;        // binary or gray, incl. wrap bit

    // memory write request, source clock domain
    typedef struct packed
    {
        logic      en;      // store this cycle
        fifoAddr_t addr;    // slot from the write pointer
        fifoData_t data;    // word to store
    } ramWrite_t;

    // The write side drives en straight from wrEn. A write while full
    // still lands in memory, so the margin above is the only slack the
    // writer gets before it overwrites unread data.

endpackage

// ==== fifoDualRam.sv ====
// --------------------
// simple dual-port memory for the FIFO
// written on srcClk, read through an output register on iDstClk
// --------------------
`timescale 1ns/1ps

module fifoDualRam
(
    input  logic               srcClk,   // write side
    input  logic               iDstClk,  // read side
    input  fifoPkg::ramWrite_t wrPort,   // enable, address, data
    input  fifoPkg::fifoAddr_t rdAddr,   // registered read address
    output fifoPkg::fifoData_t rdData    // one destination cycle after rdAddr
);
    import fifoPkg::*;

    fifoData_t mem [bufDepth];    // storage, no reset

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge srcClk)
    begin
        if (wrPort.en)
        begin
            mem[wrPort.addr] <= wrPort.data;
        end
    end

    // --------------------
    // read port
    // --------------------
    // reads every edge, validity tracked by the read-pointer block
    always_ff @(posedge iDstClk)
    begin
        rdData <= mem[rdAddr];
    end

endmodule

// ==== grayPtrSync.sv ====
// --------------------
// brings a gray pointer into another clock domain
// two flop stages, then a registered gray-to-binary step
// --------------------
`timescale 1ns/1ps

module grayPtrSync
(
    input  logic              clk,      // receiving clock
    input  logic              rst,      // reset of the receiving domain
    input  fifoPkg::fifoPtr_t grayIn,   // gray pointer from the far domain
    output fifoPkg::fifoPtr_t binOut    // binary pointer, local domain
);
    import fifoPkg::*;

    fifoPtr_t syncMeta;   // first stage, may go metastable
    fifoPtr_t syncGray;   // second stage, settled
    fifoPtr_t binNext;    // decoded pointer

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            syncMeta <= '0;
            syncGray <= '0;
            binOut   <= '0;
        end
        else
        begin
            syncMeta <= grayIn;
            syncGray <= syncMeta;
            binOut   <= binNext;   // third register, keeps the xor chain off the flags
        end
    end

    // gray to binary, msb down
    always_comb
    begin
        binNext[ptrWidth-1] = syncGray[ptrWidth-1];
        for (int i = ptrWidth - 2; i >= 0; i--)
        begin
            binNext[i] = binNext[i+1] ^ syncGray[i];
        end
    end

endmodule

// ==== fifoWritePtr.sv ====
// --------------------
// source-domain side of the FIFO
// reset sync, write pointer with gray copy, registered full flag
// --------------------
`timescale 1ns/1ps

module fifoWritePtr
(
    input  logic               srcClk,
    input  logic               reset,      // destination-domain reset
    input  logic               wrEn,       // store wrData this cycle
    input  fifoPkg::fifoData_t wrData,
    input  fifoPkg::fifoPtr_t  rdPtrSync,  // read pointer, already in this domain
    output fifoPkg::fifoPtr_t  wrGray,     // to the destination synchronizer
    output fifoPkg::ramWrite_t wrPort,     // memory write request
    output logic               full,       // margin reached
    output logic               srcReset    // reset for the source domain
);
    import fifoPkg::*;

    logic [1:0] srcRstPipe;   // reset synchronizer
    fifoPtr_t   wrPtr;        // binary, with wrap bit
    fifoPtr_t   wrPtrNext;
    fifoPtr_t   fillNext;     // words held after this edge, as seen from here

    // --------------------
    // reset into srcClk
    // --------------------
    always_ff @(posedge srcClk)
    begin
        srcRstPipe <= {srcRstPipe[0], reset};
    end

    assign srcReset = srcRstPipe[1];

    // --------------------
    // pointer and flag
    // --------------------
    assign wrPtrNext = wrPtr + fifoPtr_t'(wrEn);
    assign fillNext  = wrPtrNext - rdPtrSync;   // modulo 2*depth, never above depth

    always_ff @(posedge srcClk)
    begin
        if (srcReset)
        begin
            wrPtr  <= '0;
            wrGray <= '0;
            full   <= 1'b0;
        end
        else
        begin
            wrPtr  <= wrPtrNext;
            wrGray <= wrPtrNext ^ (wrPtrNext >> 1);   // one bit changes per step
            // stale rdPtrSync only makes this early, never late
            full   <= (fillNext >= fifoPtr_t'(bufDepth - fullMargin));
        end
    end

    // write goes out in the same cycle, at the current slot
    assign wrPort.en   = wrEn;
    assign wrPort.addr = wrPtr[addrWidth-1:0];
    assign wrPort.data = wrData;

endmodule

// ==== fifoReadPtr.sv ====
// --------------------
// destination-domain side of the FIFO
// read accept, read pointer with gray copy, empty flag, valid pipeline
// rdValid lines up with the memory output register
// --------------------
`timescale 1ns/1ps

module fifoReadPtr
(
    input  logic               iDstClk,
    input  logic               reset,
    input  logic               rdEn,       // request, ignored while empty
    input  fifoPkg::fifoPtr_t  wrPtrSync,  // write pointer, already in this domain
    output fifoPkg::fifoAddr_t rdAddr,     // address of the last accepted read
    output fifoPkg::fifoPtr_t  rdGray,     // to the source synchronizer
    output logic               empty,
    output logic               rdValid     // one strobe per accepted read
);
    import fifoPkg::*;

    logic     rdAccept;    // request that actually pops a word
    fifoPtr_t rdPtr;       // binary, with wrap bit
    fifoPtr_t rdPtrNext;
    logic     validPipe;   // first valid stage, memory address cycle

    // --------------------
    // accept and advance
    // --------------------
    assign rdAccept  = rdEn & ~empty;
    assign rdPtrNext = rdPtr + fifoPtr_t'(rdAccept);

    always_ff @(posedge iDstClk)
    begin
        if (reset)
        begin
            rdPtr     <= '0;
            rdGray    <= '0;
            empty     <= 1'b1;   // nothing written yet
            validPipe <= 1'b0;
            rdValid   <= 1'b0;
        end
        else
        begin
            rdPtr     <= rdPtrNext;
            rdGray    <= rdPtrNext ^ (rdPtrNext >> 1);
            // compare against the next pointer so the last word
            // cannot be popped twice
            empty     <= (wrPtrSync == rdPtrNext);
            validPipe <= rdAccept;    // edge k
            rdValid   <= validPipe;   // edge k+1, with the memory register
        end
    end

    // --------------------
    // read address
    // --------------------
    // held between reads, the memory keeps rereading the same word
    always_ff @(posedge iDstClk)
    begin
        if (rdAccept)
        begin
            rdAddr <= rdPtr[addrWidth-1:0];
        end
    end

    // Timing of one read accepted at edge k:
    //   edge k    rdAddr and validPipe load
    //   edge k+1  memory register loads, rdValid rises
    // the testbench sees both on the following edge, two after acceptance.
    // Back-to-back accepts give back-to-back strobes, since both the
    // address register and the valid shift move every cycle.

endmodule

// ==== fifoDualControllerGray.sv ====
// --------------------
// dual-clock FIFO top level
// write on srcClk, read on iDstClk, gray pointers cross between them
// read data and rdValid two destination cycles after an accepted read
// --------------------
`timescale 1ns/1ps

module fifoDualControllerGray
(
    input  logic               srcClk,    // write clock
    input  logic               iDstClk,   // read clock
    input  logic               reset,     // sync, active high, iDstClk domain

    // write side
    input  logic               wrEn,
    input  fifoPkg::fifoData_t wrData,
    output logic               full,      // stop writing, margin left

    // read side
    input  logic               rdEn,
    output fifoPkg::fifoData_t rdData,
    output logic               rdValid,   // rdData holds a popped word
    output logic               empty
);
    import fifoPkg::*;

    // --------------------
    // internal wires
    // --------------------
    logic      srcReset;    // reset after sync into srcClk
    fifoPtr_t  wrGray;      // source domain
    fifoPtr_t  rdGray;      // destination domain
    fifoPtr_t  wrPtrSync;   // write pointer seen by the reader
    fifoPtr_t  rdPtrSync;   // read pointer seen by the writer
    ramWrite_t wrPort;
    fifoAddr_t rdAddr;

    // --------------------
    // source domain
    // --------------------
    fifoWritePtr uWritePtr
    (
        .srcClk    (srcClk),
        .reset     (reset),
        .wrEn      (wrEn),
        .wrData    (wrData),
        .rdPtrSync (rdPtrSync),
        .wrGray    (wrGray),
        .wrPort    (wrPort),
        .full      (full),
        .srcReset  (srcReset)
    );

    // read pointer into srcClk
    grayPtrSync uRdSync
    (
        .clk    (srcClk),
        .rst    (srcReset),
        .grayIn (rdGray),
        .binOut (rdPtrSync)
    );

    // --------------------
    // destination domain
    // --------------------
    fifoReadPtr uReadPtr
    (
        .iDstClk   (iDstClk),
        .reset     (reset),
        .rdEn      (rdEn),
        .wrPtrSync (wrPtrSync),
        .rdAddr    (rdAddr),
        .rdGray    (rdGray),
        .empty     (empty),
        .rdValid   (rdValid)
    );

    // write pointer into iDstClk
    grayPtrSync uWrSync
    (
        .clk    (iDstClk),
        .rst    (reset),
        .grayIn (wrGray),
        .binOut (wrPtrSync)
    );

    // --------------------
    // storage
    // --------------------
    fifoDualRam uDualRam
    (
        .srcClk  (srcClk),
        .iDstClk (iDstClk),
        .wrPort  (wrPort),
        .rdAddr  (rdAddr),
        .rdData  (rdData)   // straight from the memory output register
    );

endmodule

// ==== tbFifoDual.sv ====
// --------------------
// testbench for the dual-clock FIFO
// queue reference model, data compare, read latency check, watchdog
// --------------------
`timescale 1ns/1ps

module tbFifoDual;
    import fifoPkg::*;

    // --------------------
    // run lengths
    // --------------------
    localparam int resetCycles      = 10;
    localparam int burstWords       = 40;
    localparam int randomWords      = 600;
    localparam int plannedTransfers = burstWords + bufDepth + randomWords;
    localparam int slowPeriod       = 10;   // iDstClk is the slower clock, ns
    localparam int runLimit = (plannedTransfers + resetCycles) * slowPeriod * 4;

    logic      srcClk;
    logic      iDstClk;
    logic      reset;
    logic      wrEn;
    fifoData_t wrData;
    logic      full;
    logic      rdEn;
    fifoData_t rdData;
    logic      rdValid;
    logic      empty;

    fifoData_t refQ [$];          // written words, oldest first
    int        errCount    = 0;
    int        writeCount  = 0;   // words pushed into the model
    int        strobeCount = 0;   // rdValid cycles
    int        acceptCount = 0;   // rdEn high while not empty
    integer    seed        = 66;
    integer    rdSeed;            // reader stream, drawn from seed
    logic      acceptD1;          // accept one edge back
    logic      acceptD2;          // two edges back
    int        issued;            // writes issued in the fill phase

    fifoDualControllerGray UUT
    (
        .srcClk  (srcClk),
        .iDstClk (iDstClk),
        .reset   (reset),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .full    (full),
        .rdEn    (rdEn),
        .rdData  (rdData),
        .rdValid (rdValid),
        .empty   (empty)
    );

    always #5 iDstClk = ~iDstClk;   // 10 ns
    always #3.5 srcClk = ~srcClk;   // 7 ns

    // --------------------
    // compare and reference
    // --------------------
    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
    begin
        if (actual !== expected)
        begin
            errCount++;
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    end
    endtask

    // next word in write order
    function automatic fifoData_t expectedWord();
        fifoData_t w;
        if (refQ.size() == 0)
        begin
            errCount++;
            $display("a word was read at %0t ns but none was left to read", $time);
            w = 'x;
        end
        else
        begin
            w = refQ.pop_front();
        end
        return w;
    endfunction

    // model follows the write port
    always @(posedge srcClk)
    begin
        if (wrEn === 1'b1)
        begin
            refQ.push_back(wrData);
            writeCount++;
        end
    end

    always @(posedge iDstClk)
    begin
        if (!reset && rdValid)
        begin
            strobeCount++;
            checkEqual(32'(rdData), 32'(expectedWord()), "read data");
        end
    end

    // each accepted read must give rdValid two edges later
    always @(posedge iDstClk)
    begin
        if (reset)
        begin
            acceptD1 = 1'b0;
            acceptD2 = 1'b0;
        end
        else
        begin
            checkEqual(32'(rdValid), 32'(acceptD2), "rdValid two cycles after accept");
            acceptD2 = acceptD1;
            acceptD1 = rdEn && !empty;
            if (acceptD1)
            begin
                acceptCount++;
            end
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------
    task automatic writeBurst(input int n);
    begin
        for (int i = 0; i < n; i++)
        begin
            @(posedge srcClk);
            wrEn   <= 1'b1;
            wrData <= fifoData_t'($random(seed));
        end
        @(posedge srcClk);
        wrEn <= 1'b0;
    end
    endtask

    // exactly n accepts, empty gates the rest
    task automatic readWords(input int n);
        int got;
    begin
        got = 0;
        while (got < n)
        begin
            @(posedge iDstClk);
            if (rdEn && !empty)
            begin
                got++;
            end
            rdEn <= (got < n);
        end
    end
    endtask

    task automatic writeUntilFull();
        logic stop;
    begin
        stop   = 1'b0;
        issued = 0;
        while (!stop && issued <= bufDepth)   // bound in case full never comes
        begin
            @(posedge srcClk);
            if (full)
            begin
                wrEn <= 1'b0;
                stop = 1'b1;
            end
            else
            begin
                wrEn   <= 1'b1;
                wrData <= fifoData_t'($random(seed));
                issued++;
            end
        end
        wrEn <= 1'b0;
    end
    endtask

    task automatic randomWriter(input int n);
        int         cnt;
        logic [31:0] pick;
    begin
        cnt = 0;
        while (cnt < n)
        begin
            @(posedge srcClk);
            pick = $random(seed);
            if (!full && pick[0])
            begin
                wrEn   <= 1'b1;
                wrData <= fifoData_t'($random(seed));
                cnt++;
            end
            else
            begin
                wrEn <= 1'b0;
            end
        end
        @(posedge srcClk);
        wrEn <= 1'b0;
    end
    endtask

    task automatic randomReader(input int n);
        int         got;
        logic [31:0] pick;
    begin
        got = 0;
        while (got < n)
        begin
            @(posedge iDstClk);
            if (rdEn && !empty)
            begin
                got++;
            end
            pick = $random(rdSeed);
            rdEn <= (got < n) && pick[1];
        end
    end
    endtask

    // counters move on posedge, so look on negedge
    task automatic waitStrobes(input int target);
    begin
        while (strobeCount < target)
        begin
            @(negedge iDstClk);
        end
        repeat (3) @(posedge iDstClk);
    end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial
    begin
        int spin;
        srcClk  = 1'b0;
        iDstClk = 1'b0;
        reset   = 1'b1;
        wrEn    = 1'b0;
        wrData  = '0;
        rdEn    = 1'b0;
        rdSeed  = $random(seed);
        repeat (resetCycles) @(posedge iDstClk);
        reset <= 1'b0;
        repeat (6) @(posedge srcClk);   // source reset trails by two edges

        // idle flags, rdEn on empty is ignored
        @(posedge iDstClk);
        checkEqual(32'(empty), 1, "empty after reset");
        checkEqual(32'(rdValid), 0, "rdValid after reset");
        @(posedge srcClk);
        checkEqual(32'(full), 0, "full after reset");
        repeat (4)
        begin
            @(posedge iDstClk);
            rdEn <= 1'b1;
            @(posedge iDstClk);
            rdEn <= 1'b0;
        end
        repeat (4) @(posedge iDstClk);
        @(negedge iDstClk);
        checkEqual(32'(strobeCount), 0, "strobes while empty");
        checkEqual(32'(acceptCount), 0, "accepts while empty");

        // burst in, then read back
        writeBurst(burstWords);
        readWords(burstWords);
        waitStrobes(writeCount);
        repeat (8) @(posedge srcClk);   // read pointer settles on the write side

        // fill to the margin
        writeUntilFull();
        // full rises on the edge that stores word bufDepth-fullMargin, one more is in flight
        checkEqual(32'(issued), 32'(bufDepth - fullMargin + 1), "writes issued before full");
        repeat (8) @(posedge srcClk);
        checkEqual(32'(full), 1, "full held with no reads");
        readWords(10);
        spin = 0;
        do
        begin
            @(posedge srcClk);
            spin++;
        end
        while (full && spin < 20);
        checkEqual(32'(full), 0, "full after reads freed space");
        readWords(issued - 10);
        waitStrobes(writeCount);

        // both sides at random
        fork
            randomWriter(randomWords);
            randomReader(randomWords);
        join
        waitStrobes(writeCount);

        @(negedge iDstClk);
        checkEqual(32'(refQ.size()), 0, "words left in the reference queue");
        checkEqual(32'(strobeCount), 32'(acceptCount), "strobes against accepted reads");
        checkEqual(32'(strobeCount), 32'(writeCount), "words read against words written");
        $display("errors %0d, transfers %0d, written %0d", errCount, strobeCount, writeCount);
        if (errCount == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        #(runLimit);
        $display("timeout: the run did not finish within %0d ns (errors %0d, transfers %0d)",
                 runLimit, errCount, strobeCount);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sim.f ====
fifoPkg.sv
fifoDualRam.sv
grayPtrSync.sv
fifoWritePtr.sv
fifoReadPtr.sv
fifoDualControllerGray.sv
tbFifoDual.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO
# make          build and run, verdict from the log
# make lint     lint only
# make clean    remove build output and log

VERILATOR ?= verilator
TOP       ?= tbFifoDual
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ** PASS **
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --timescale $(TIMESCALE)

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# the simulator exit code is not trusted, the log decides
run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF -e '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
